/* Makefile */
# Verilator build and run of the AVR multiply unit testbench
SRCS := $(shell cat filelist.f)

obj_dir/Vtb_avr_mul_top: $(SRCS) filelist.f
	verilator --binary --timing --assert --top-module tb_avr_mul_top -f filelist.f

run: obj_dir/Vtb_avr_mul_top
	-./obj_dir/Vtb_avr_mul_top > sim.log 2>&1
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* avr_mul.sv */
/*
 Two-stage AVR multiplier, carry-save array then a registered final add
 Product, C and Z are valid in the cycle after the operands are sampled
 Outputs read zero unless the bus start bit marks a result cycle
 USE_RST = 0 removes the asynchronous reset from the pipeline registers
*/

`timescale 1ns/100ps

module avr_mul import avr_mul_pkg::*;
#(
   parameter int USE_RST = 1
)
(
   input  logic              cp2,
   input  logic              ireset,
   input  logic              cp2en,
   mul_bus_if.mul            bus,
   output logic [PROD_W-1:0] mr_out,
   output logic              mc_out,   // C flag
   output logic              mz_out    // Z flag
);

   logic [PROD_W-1:0] p_sum;
   logic [PROD_W-1:0] p_carry;
   logic [PROD_W-1:0] p_carry_sh;
   logic [PROD_W-1:0] sum_q;
   logic [PROD_W-1:0] carry_q;
   logic              rd_zero_q;
   logic              rr_zero_q;
   logic [PROD_W-1:0] adder_out;
   logic [PROD_W-1:0] prod;

   mul8x8comb u_mul8x8comb
   (
      .rd_in       (bus.rd),
      .rr_in       (bus.rr),
      .muls        (bus.muls),
      .mulsu       (bus.mulsu),
      .p_sum_out   (p_sum),
      .p_carry_out (p_carry)
   );

   assign p_carry_sh = {p_carry[PROD_W-2:0], 1'b0};

   // ***********************************************************
   // Pipeline registers
   // ***********************************************************
   generate
      if (USE_RST != 0)
      begin : g_rst
         always_ff @(posedge cp2 or negedge ireset)
         begin
            if (!ireset)
            begin
               sum_q     <= '0;
               carry_q   <= '0;
               rd_zero_q <= 1'b0;
               rr_zero_q <= 1'b0;
            end
            else if (cp2en)
            begin
               sum_q     <= p_sum;
               carry_q   <= p_carry_sh;
               rd_zero_q <= (bus.rd == 8'h00);
               rr_zero_q <= (bus.rr == 8'h00);
            end
         end
      end
      else
      begin : g_no_rst
         always_ff @(posedge cp2)
         begin
            if (cp2en)
            begin
               sum_q     <= p_sum;
               carry_q   <= p_carry_sh;
               rd_zero_q <= (bus.rd == 8'h00);
               rr_zero_q <= (bus.rr == 8'h00);
            end
         end
      end
   endgenerate

   // ***********************************************************
   // Final add, fractional shift and flags
   // ***********************************************************
   assign adder_out = sum_q + carry_q;
   assign prod      = bus.fmul ? {adder_out[PROD_W-2:0], 1'b0} : adder_out;

   assign mr_out = bus.start ? prod : '0;
   assign mc_out = bus.start & adder_out[PROD_W-1];   // Bit 15 before the shift
   // A zero operand is the only way to a zero result, FMUL forms included
   assign mz_out = bus.start & (rd_zero_q | rr_zero_q);

endmodule

/* avr_mul_pkg.sv */
/*
 Shared types and widths for the AVR multiply unit
 Register file is fixed at 32 entries of 8 bits, product at 16 bits
 Opcode encoding is internal only and is not the AVR instruction word
*/

package avr_mul_pkg;

   localparam int REG_ADDR_W = 5;                 // r0..r31
   localparam int NUM_REGS   = 2 ** REG_ADDR_W;
   localparam int DATA_W     = 8;
   localparam int PROD_W     = 16;                // r1:r0 pair

   // Decoded multiply operation
   typedef enum logic [2:0]
   {
      OP_NONE   = 3'd0,
      OP_MUL    = 3'd1,
      OP_MULS   = 3'd2,
      OP_MULSU  = 3'd3,
      OP_FMUL   = 3'd4,
      OP_FMULS  = 3'd5,
      OP_FMULSU = 3'd6
   } mul_op_t;

   // SREG bits touched by the multiply group
   typedef struct packed
   {
      logic c;
      logic z;
   } mul_flags_t;

endpackage

/* avr_mul_top.sv */
/*
 AVR multiply unit top level: control, register file, multiplier
 One enabled cycle from issue to write-back, cp2en low freezes everything
 Flag outputs are meaningful only while wb_en is high
*/

`timescale 1ns/100ps

module avr_mul_top import avr_mul_pkg::*;
#(
   parameter int USE_RST = 1
)
(
   input  logic                  cp2,
   input  logic                  ireset,
   input  logic                  cp2en,
   input  logic [15:0]           instr,
   input  logic                  instr_valid,
   output logic                  instr_ready,
   input  logic                  load_en,
   input  logic [REG_ADDR_W-1:0] load_addr,
   input  logic [DATA_W-1:0]     load_data,
   output logic                  wb_en,
   output logic [PROD_W-1:0]     wb_data,
   output logic                  flag_c,
   output logic                  flag_z
);

   logic [REG_ADDR_W-1:0] rd_addr;
   logic [REG_ADDR_W-1:0] rr_addr;
   logic [DATA_W-1:0]     rd_data;
   logic [DATA_W-1:0]     rr_data;
   logic [PROD_W-1:0]     mr_out;
   logic                  mc_out;
   logic                  mz_out;

   mul_bus_if u_bus ();

   mul_ctrl #(.USE_RST(USE_RST)) u_ctrl
   (
      .cp2         (cp2),
      .ireset      (ireset),
      .cp2en       (cp2en),
      .instr       (instr),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .rd_addr     (rd_addr),
      .rr_addr     (rr_addr),
      .rd_data     (rd_data),
      .rr_data     (rr_data),
      .mr_out      (mr_out),
      .mc_out      (mc_out),
      .mz_out      (mz_out),
      .wb_en       (wb_en),
      .wb_data     (wb_data),
      .flag_c      (flag_c),
      .flag_z      (flag_z),
      .bus         (u_bus.ctrl)
   );

   avr_reg_file u_reg_file
   (
      .cp2       (cp2),
      .ireset    (ireset),
      .cp2en     (cp2en),
      .rd_addr   (rd_addr),
      .rr_addr   (rr_addr),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .wb_en     (wb_en),      // Product to r1:r0
      .wb_data   (wb_data),
      .rd_data   (rd_data),
      .rr_data   (rr_data)
   );

   avr_mul #(.USE_RST(USE_RST)) u_mul
   (
      .cp2    (cp2),
      .ireset (ireset),
      .cp2en  (cp2en),
      .bus    (u_bus.mul),
      .mr_out (mr_out),
      .mc_out (mc_out),
      .mz_out (mz_out)
   );

endmodule

/* avr_reg_file.sv */
/*
 32 x 8 register file, two combinational read ports
 Host load and r1:r0 product write-back share the enabled edge
 Write-back wins over a host load to r0/r1 in the same cycle
 Reads return the old value during a write
*/

`timescale 1ns/100ps

module avr_reg_file import avr_mul_pkg::*;
(
   input  logic                  cp2,
   input  logic                  ireset,
   input  logic                  cp2en,
   input  logic [REG_ADDR_W-1:0] rd_addr,
   input  logic [REG_ADDR_W-1:0] rr_addr,
   input  logic                  load_en,
   input  logic [REG_ADDR_W-1:0] load_addr,
   input  logic [DATA_W-1:0]     load_data,
   input  logic                  wb_en,
   input  logic [PROD_W-1:0]     wb_data,
   output logic [DATA_W-1:0]     rd_data,
   output logic [DATA_W-1:0]     rr_data
);

   logic [DATA_W-1:0] regs [NUM_REGS];

   // ***********************************************************
   // Write ports
   // ***********************************************************
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (cp2en)
      begin
         if (load_en)
         begin
            regs[load_addr] <= load_data;
         end
         // Later assignment overrides a load to r0/r1
         if (wb_en)
         begin
            regs[0] <= wb_data[DATA_W-1:0];        // Low byte
            regs[1] <= wb_data[PROD_W-1:DATA_W];   // High byte
         end
      end
   end

   // ***********************************************************
   // Read ports
   // ***********************************************************
   assign rd_data = regs[rd_addr];
   assign rr_data = regs[rr_addr];

endmodule

/* filelist.f */
avr_mul_pkg.sv
mul_bus_if.sv
avr_reg_file.sv
mul8x8comb.sv
avr_mul.sv
mul_ctrl.sv
avr_mul_top.sv
tb_avr_mul_top.sv

/* mul8x8comb.sv */
/*
 Combinational 8x8 partial-product array with carry-save reduction
 Output pair satisfies sum + (carry << 1) == product mod 2^16
 muls gives signed x signed, mulsu gives signed Rd x unsigned Rr
*/

`timescale 1ns/100ps

module mul8x8comb
(
   input  logic [7:0]  rd_in,
   input  logic [7:0]  rr_in,
   input  logic        muls,
   input  logic        mulsu,
   output logic [15:0] p_sum_out,
   output logic [15:0] p_carry_out
);

   // Negated weights become inverted bits plus these constants
   localparam logic [15:0] CORR_MULS  = 16'h8100;
   localparam logic [15:0] CORR_MULSU = 16'h8080;

   logic        rd_signed;
   logic        rr_signed;
   logic [15:0] row [9];   // Eight partial products plus correction
   logic [15:0] lvl1 [6];
   logic [15:0] lvl2 [4];
   logic [15:0] lvl3 [3];

   function automatic logic [15:0] xor3(input logic [15:0] a, input logic [15:0] b,
                                        input logic [15:0] c);
      return a ^ b ^ c;
   endfunction

   function automatic logic [15:0] maj3(input logic [15:0] a, input logic [15:0] b,
                                        input logic [15:0] c);
      return (a & b) | (a & c) | (b & c);
   endfunction

   assign rd_signed = muls | mulsu;
   assign rr_signed = muls;

   // ***********************************************************
   // Partial products, Baugh-Wooley style sign handling
   // ***********************************************************
   always_comb
   begin
      for (int j = 0; j < 8; j++)
      begin
         row[j] = '0;
         for (int i = 0; i < 8; i++)
         begin
            // Invert bits carrying a negative weight
            row[j][i+j] = (rd_in[i] & rr_in[j]) ^
                          (((i == 7) & rd_signed) ^ ((j == 7) & rr_signed));
         end
      end
      if (muls)
         row[8] = CORR_MULS;
      else if (mulsu)
         row[8] = CORR_MULSU;
      else
         row[8] = '0;
   end

   // ***********************************************************
   // Carry-save tree, 9 -> 6 -> 4 -> 3 -> 2
   // ***********************************************************
   always_comb
   begin
      for (int k = 0; k < 3; k++)
      begin
         lvl1[2*k]   = xor3(row[3*k], row[3*k+1], row[3*k+2]);
         lvl1[2*k+1] = maj3(row[3*k], row[3*k+1], row[3*k+2]) << 1;
      end
      for (int k = 0; k < 2; k++)
      begin
         lvl2[2*k]   = xor3(lvl1[3*k], lvl1[3*k+1], lvl1[3*k+2]);
         lvl2[2*k+1] = maj3(lvl1[3*k], lvl1[3*k+1], lvl1[3*k+2]) << 1;
      end
      lvl3[0] = xor3(lvl2[0], lvl2[1], lvl2[2]);
      lvl3[1] = maj3(lvl2[0], lvl2[1], lvl2[2]) << 1;
      lvl3[2] = lvl2[3];   // Passes to the last stage
   end

   // Last carry left unshifted, the multiplier aligns it
   assign p_sum_out   = xor3(lvl3[0], lvl3[1], lvl3[2]);
   assign p_carry_out = maj3(lvl3[0], lvl3[1], lvl3[2]);

endmodule

/* mul_bus_if.sv */
/*
 Operand and control bus from the multiply control to the multiplier
 rd, rr, muls, mulsu belong to the issue cycle
 fmul and start belong to the result cycle, one enabled edge later
*/

`timescale 1ns/100ps

interface mul_bus_if;

   logic [7:0] rd;     // Rd operand, register file read data
   logic [7:0] rr;     // Rr operand
   logic       muls;   // MULS/FMULS, both signed
   logic       mulsu;  // MULSU/FMULSU, Rd signed only
   logic       fmul;   // Fractional shift of the result
   logic       start;  // Result cycle holds a valid product

   modport ctrl
   (
      output rd,
      output rr,
      output muls,
      output mulsu,
      output fmul,
      output start
   );

   modport mul
   (
      input rd,
      input rr,
      input muls,
      input mulsu,
      input fmul,
      input start
   );

endinterface

/* mul_ctrl.sv */
/*
 Multiply control: opcode decode, operand addressing, one result in flight
 instr_ready drops while a result is pending and the next
 instruction reads r0 or r1. Undecodable words retire with no write-back
 USE_RST = 0 removes the asynchronous reset from the in-flight record
*/

`timescale 1ns/100ps

module mul_ctrl import avr_mul_pkg::*;
#(
   parameter int USE_RST = 1
)
(
   input  logic                  cp2,
   input  logic                  ireset,
   input  logic                  cp2en,
   input  logic [15:0]           instr,
   input  logic                  instr_valid,
   output logic                  instr_ready,
   output logic [REG_ADDR_W-1:0] rd_addr,
   output logic [REG_ADDR_W-1:0] rr_addr,
   input  logic [DATA_W-1:0]     rd_data,
   input  logic [DATA_W-1:0]     rr_data,
   input  logic [PROD_W-1:0]     mr_out,
   input  logic                  mc_out,
   input  logic                  mz_out,
   output logic                  wb_en,
   output logic [PROD_W-1:0]     wb_data,
   output logic                  flag_c,
   output logic                  flag_z,
   mul_bus_if.ctrl               bus
);

   mul_op_t    dec_op;
   mul_op_t    op_q;            // Operation in flight
   mul_op_t    op_next;
   logic       inflight;
   logic       inflight_fmul;
   logic       reads_low;       // Waiting instruction reads r0/r1
   mul_flags_t res_flags;

   // ***********************************************************
   // Decode
   // ***********************************************************
   always_comb
   begin
      dec_op  = OP_NONE;
      rd_addr = instr[8:4];                  // MUL, any register
      rr_addr = {instr[9], instr[3:0]};
      if (instr[15:10] == 6'b100111)
         dec_op = OP_MUL;
      else if (instr[15:8] == 8'h02)
      begin
         dec_op  = OP_MULS;
         rd_addr = {1'b1, instr[7:4]};       // r16..r31
         rr_addr = {1'b1, instr[3:0]};
      end
      else if (instr[15:8] == 8'h03)
      begin
         rd_addr = {2'b10, instr[6:4]};      // r16..r23
         rr_addr = {2'b10, instr[2:0]};
         case ({instr[7], instr[3]})
            2'b00:   dec_op = OP_MULSU;
            2'b01:   dec_op = OP_FMUL;
            2'b10:   dec_op = OP_FMULS;
            default: dec_op = OP_FMULSU;
         endcase
      end
   end

   // Hazard on the pending r1:r0 write
   assign reads_low   = (dec_op != OP_NONE) &&
                        ((rd_addr[REG_ADDR_W-1:1] == '0) || (rr_addr[REG_ADDR_W-1:1] == '0));
   assign instr_ready = !(inflight && instr_valid && reads_low);
   assign op_next     = (instr_valid && instr_ready) ? dec_op : OP_NONE;

   // ***********************************************************
   // In-flight record
   // ***********************************************************
   generate
      if (USE_RST != 0)
      begin : g_rst
         always_ff @(posedge cp2 or negedge ireset)
         begin
            if (!ireset)
               op_q <= OP_NONE;
            else if (cp2en)
               op_q <= op_next;
         end
      end
      else
      begin : g_no_rst
         always_ff @(posedge cp2)
         begin
            if (cp2en)
               op_q <= op_next;
         end
      end
   endgenerate

   assign inflight      = (op_q != OP_NONE);
   assign inflight_fmul = (op_q == OP_FMUL) || (op_q == OP_FMULS) || (op_q == OP_FMULSU);

   // Multiplier bus, operands now and result controls one stage later
   assign bus.rd    = rd_data;
   assign bus.rr    = rr_data;
   assign bus.muls  = (dec_op == OP_MULS) || (dec_op == OP_FMULS);
   assign bus.mulsu = (dec_op == OP_MULSU) || (dec_op == OP_FMULSU);
   assign bus.fmul  = inflight_fmul;
   assign bus.start = inflight;

   // Write-back
   assign res_flags.c = mc_out;
   assign res_flags.z = mz_out;
   assign wb_en       = inflight;
   assign wb_data     = mr_out;
   assign flag_c      = res_flags.c;
   assign flag_z      = res_flags.z;

endmodule

/* tb_avr_mul_top.sv */
/*
 Testbench for the AVR multiply unit, inputs change on the falling edge
 A posedge monitor keeps a register copy and predicts every write-back
 Registers r0/r1 are never chosen as operands except in the hazard test
*/

`timescale 1ns/100ps

module tb_avr_mul_top import avr_mul_pkg::*;
();

   // Runs per opcode times cycles per run, plus the directed tests
   localparam int STIM_CYCLES = 6 * 15 * 3 + 80;
   localparam int CYCLE_LIMIT = 4 * STIM_CYCLES;

   logic                  cp2 = 1'b0;
   logic                  ireset;
   logic                  cp2en;
   logic [15:0]           instr;
   logic                  instr_valid;
   logic                  instr_ready;
   logic                  load_en;
   logic [REG_ADDR_W-1:0] load_addr;
   logic [DATA_W-1:0]     load_data;
   logic                  wb_en;
   logic [PROD_W-1:0]     wb_data;
   logic                  flag_c;
   logic                  flag_z;

   mul_op_t               cur_op;          // What the word on instr means
   logic [REG_ADDR_W-1:0] cur_d;
   logic [REG_ADDR_W-1:0] cur_r;
   string                 test_name;
   logic [7:0]            model_regs [32];
   logic [17:0]           exp_q [$];       // {c, z, product}
   logic [31:0]           lcg_state;
   int                    cycle_count = 0;

   avr_mul_top #(.USE_RST(1)) u_dut
   (
      .cp2         (cp2),
      .ireset      (ireset),
      .cp2en       (cp2en),
      .instr       (instr),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .wb_en       (wb_en),
      .wb_data     (wb_data),
      .flag_c      (flag_c),
      .flag_z      (flag_z)
   );

   always #10 cp2 = ~cp2;

   // ************************************************************
   // Reference rules and helpers
   // ************************************************************
   function automatic int rand_below(input int n);
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return int'(lcg_state[30:16]) % n;
   endfunction

   function automatic logic [7:0] corner_val(input int k);
      case (k)
         0:       return 8'h00;
         1:       return 8'h80;
         default: return 8'hFF;
      endcase
   endfunction

   function automatic mul_op_t op_from_index(input int k);
      case (k)
         0:       return OP_MUL;
         1:       return OP_MULS;
         2:       return OP_MULSU;
         3:       return OP_FMUL;
         4:       return OP_FMULS;
         default: return OP_FMULSU;
      endcase
   endfunction

   // AVR instruction words
   function automatic logic [15:0] encode(input mul_op_t op, input int d, input int r);
      logic [4:0] dd;
      logic [4:0] rr;
      dd = d[4:0];
      rr = r[4:0];
      case (op)
         OP_MUL:    return {6'b100111, rr[4], dd, rr[3:0]};
         OP_MULS:   return {8'h02, dd[3:0], rr[3:0]};
         OP_MULSU:  return {8'h03, 1'b0, dd[2:0], 1'b0, rr[2:0]};
         OP_FMUL:   return {8'h03, 1'b0, dd[2:0], 1'b1, rr[2:0]};
         OP_FMULS:  return {8'h03, 1'b1, dd[2:0], 1'b0, rr[2:0]};
         OP_FMULSU: return {8'h03, 1'b1, dd[2:0], 1'b1, rr[2:0]};
         default:   return 16'hFFFF;
      endcase
   endfunction

   function automatic logic [17:0] model_result(input mul_op_t op, input logic [7:0] a,
                                                input logic [7:0] b);
      logic        a_signed;
      logic        b_signed;
      logic        frac;
      int          prod;
      logic [15:0] raw;
      logic [15:0] res;
      a_signed = (op == OP_MULS) || (op == OP_MULSU) || (op == OP_FMULS) || (op == OP_FMULSU);
      b_signed = (op == OP_MULS) || (op == OP_FMULS);
      frac     = (op == OP_FMUL) || (op == OP_FMULS) || (op == OP_FMULSU);
      prod = (a_signed ? int'($signed(a)) : int'(a)) * (b_signed ? int'($signed(b)) : int'(b));
      raw  = prod[15:0];
      res  = frac ? {raw[14:0], 1'b0} : raw;    // C comes from before the shift
      return {raw[15], (res == 16'h0000), res};
   endfunction

   task automatic fail_value(input string what, input logic [15:0] exp, input logic [15:0] act);
      $display("** Error: %s, %s expected %h, actual %h", test_name, what, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
   endtask

   task automatic fail_text(input string text);
      $display("Error in %s: %s", test_name, text);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
   endtask

   // Operand registers per opcode, r0/r1 excluded, d and r differ
   task automatic pick_regs(input mul_op_t op, output int d, output int r);
      int lo;
      int n;
      if (op == OP_MUL)
      begin
         lo = 2;
         n  = 30;
      end
      else if (op == OP_MULS)
      begin
         lo = 16;
         n  = 16;
      end
      else
      begin
         lo = 16;
         n  = 8;
      end
      d = lo + rand_below(n);
      r = lo + (d - lo + 1 + rand_below(n - 1)) % n;
   endtask

   task automatic set_idle();
      instr_valid = 1'b0;
      load_en     = 1'b0;
      cur_op      = OP_NONE;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge cp2);
         set_idle();
      end
   endtask

   task automatic load_reg(input int addr, input logic [7:0] val);
      @(negedge cp2);
      set_idle();
      load_en   = 1'b1;
      load_addr = addr[REG_ADDR_W-1:0];
      load_data = val;
      @(posedge cp2);
   endtask

   // Holds the word until an enabled edge accepts it
   task automatic issue(input logic [15:0] word, input mul_op_t op, input int d, input int r,
                        output int stalls);
      @(negedge cp2);
      set_idle();
      instr       = word;
      instr_valid = 1'b1;
      cur_op      = op;
      cur_d       = d[REG_ADDR_W-1:0];
      cur_r       = r[REG_ADDR_W-1:0];
      stalls      = 0;
      @(posedge cp2);
      while (!(cp2en && instr_ready))
      begin
         stalls++;
         @(posedge cp2);
      end
   endtask

   task automatic run_op(input mul_op_t op, input logic [7:0] a, input logic [7:0] b);
      int d;
      int r;
      int stalls;
      pick_regs(op, d, r);
      load_reg(d, a);
      load_reg(r, b);
      issue(encode(op, d, r), op, d, r, stalls);
      assert (stalls == 0) else fail_text("instr_ready dropped with no hazard");
   endtask

   // ************************************************************
   // Monitor and reference model
   // ************************************************************
   always @(posedge cp2)
   begin : monitor
      logic [17:0] head;
      if (!ireset)
      begin
         exp_q.delete();
         model_regs = '{default: 8'h00};
      end
      else if (cp2en)
      begin
         assert (!wb_en || exp_q.size() != 0) else fail_text("write-back with nothing pending");
         assert (wb_en || exp_q.size() == 0) else fail_text("expected write-back missing");
         // Operands are read before this edge's writes
         if (instr_valid && instr_ready && (cur_op != OP_NONE))
            exp_q.push_back(model_result(cur_op, model_regs[cur_d], model_regs[cur_r]));
         if (load_en)
            model_regs[load_addr] = load_data;
         if (wb_en && (exp_q.size() != 0))
         begin
            head = exp_q.pop_front();
            assert (wb_data == head[15:0]) else fail_value("wb_data", head[15:0], wb_data);
            assert (flag_c == head[17]) else fail_value("flag_c", {15'd0, head[17]}, {15'd0, flag_c});
            assert (flag_z == head[16]) else fail_value("flag_z", {15'd0, head[16]}, {15'd0, flag_z});
            model_regs[0] = head[7:0];     // Write-back wins over a load
            model_regs[1] = head[15:8];
         end
      end
   end

   always @(posedge cp2)
   begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT)
      begin
         $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

   // ************************************************************
   // Stimulus
   // ************************************************************
   initial
   begin : stimulus
      int      stalls;
      int      d;
      int      r;
      mul_op_t op;
      ireset      = 1'b0;
      cp2en       = 1'b1;
      instr       = 16'h0000;
      instr_valid = 1'b0;
      load_en     = 1'b0;
      load_addr   = '0;
      load_data   = '0;
      cur_op      = OP_NONE;
      cur_d       = '0;
      cur_r       = '0;
      lcg_state   = 32'd12394;
      test_name   = "reset";
      repeat (5) @(negedge cp2);
      ireset = 1'b1;
      @(negedge cp2);
      assert (!wb_en && instr_ready) else fail_text("wb_en or instr_ready wrong after reset");

      for (int k = 0; k < 6; k++)
      begin
         op = op_from_index(k);
         test_name = $sformatf("%s corners", op.name());
         for (int i = 0; i < 3; i++)
         begin
            for (int j = 0; j < 3; j++)
            begin
               run_op(op, corner_val(i), corner_val(j));
            end
         end
         test_name = $sformatf("%s random", op.name());
         for (int n = 0; n < 6; n++)
         begin
            run_op(op, 8'(rand_below(256)), 8'(rand_below(256)));
         end
      end

      test_name = "back-to-back";
      for (int n = 2; n < 32; n++)
      begin
         load_reg(n, 8'(rand_below(256)));
      end
      for (int n = 0; n < 8; n++)
      begin
         op = op_from_index(rand_below(6));
         pick_regs(op, d, r);
         issue(encode(op, d, r), op, d, r, stalls);
         assert (stalls == 0) else fail_text("gap in back-to-back issue");
      end

      test_name = "r0/r1 hazard";
      load_reg(2, 8'h5A);
      load_reg(3, 8'hC3);
      issue(encode(OP_MUL, 2, 3), OP_MUL, 2, 3, stalls);
      issue(encode(OP_MUL, 0, 1), OP_MUL, 0, 1, stalls);
      assert (stalls == 1) else fail_text("read of r0/r1 did not stall exactly one cycle");
      issue(encode(OP_MUL, 1, 4), OP_MUL, 1, 4, stalls);
      assert (stalls == 1) else fail_text("read of r1 did not stall exactly one cycle");

      test_name = "cp2en freeze";
      issue(encode(OP_FMULS, 16, 17), OP_FMULS, 16, 17, stalls);
      @(negedge cp2);
      set_idle();
      cp2en     = 1'b0;
      instr     = encode(OP_MUL, 2, 3);   // Other operands on the read ports
      load_en   = 1'b1;         // Ignored while disabled
      load_addr = 5'd5;
      load_data = 8'hA5;
      repeat (4)
      begin
         @(negedge cp2);
         assert (wb_en) else fail_text("pending result lost while cp2en low");
      end
      set_idle();
      cp2en = 1'b1;
      issue(encode(OP_MUL, 5, 16), OP_MUL, 5, 16, stalls);

      test_name = "reset with result in flight";
      issue(encode(OP_MULSU, 18, 19), OP_MULSU, 18, 19, stalls);
      @(negedge cp2);
      set_idle();
      ireset      = 1'b0;
      instr       = encode(OP_MUL, 0, 1);   // Stalls if the pending result survives
      instr_valid = 1'b1;
      repeat (5) @(negedge cp2);
      assert (!wb_en && instr_ready) else fail_text("wb_en or instr_ready wrong in reset");
      set_idle();
      ireset = 1'b1;

      test_name = "undecodable opcode";
      issue(16'hFFFF, OP_NONE, 0, 0, stalls);
      issue(16'h0000, OP_NONE, 0, 0, stalls);
      load_reg(20, 8'h9C);
      load_reg(21, 8'h37);
      issue(encode(OP_MUL, 20, 21), OP_MUL, 20, 21, stalls);
      idle(3);

      if (exp_q.size() == 0)
      begin
         $display("STATUS: PASS");
         $finish;
      end
      else
      begin
         fail_text("results still pending at end of run");
      end
   end

endmodule
